// File: logic/apb_i2c_ctrl.sv
// APB register block for the I2C master: TX, RX, command and status registers
`timescale 1ns/1ns

module apb_i2c_ctrl (
	input  logic                        scl,
	input  logic                        rst_i,
	input  logic [apb_regs_pkg::APB_AW-1:0] paddr_i,
	input  logic                        psel_i,
	input  logic                        penable_i,
	input  logic                        pwrite_i,
	input  logic [apb_regs_pkg::APB_DW-1:0] pwdata_i,
	output logic [apb_regs_pkg::APB_DW-1:0] prdata_o,
	output logic                        pready_o,
	output logic                        pslverr_o,
	output logic                        cmd_go_o,
	output logic                        cmd_sta_o,
	output logic                        cmd_sto_o,
	output logic                        cmd_rd_o,
	output logic                        cmd_wr_o,
	output logic                        cmd_nack_o,
	output logic [7:0]                  tx_byte_o,
	input  logic                        done_i,
	input  logic [7:0]                  rx_byte_i,
	input  logic                        rx_nack_i
);

	import apb_regs_pkg::*;

	logic              acc_wr;
	logic              cmd_hit;
	logic              cmd_take;
	logic              busy_q;
	logic              rxnack_q;
	logic              go_q;
	logic [CMD_W-1:0]  cmd_q;
	logic [7:0]        tx_q;
	logic [7:0]        rx_q;

	// no wait states, every access phase completes
	assign pready_o = 1'b1;

	assign acc_wr   = psel_i && penable_i && pwrite_i;
	assign cmd_hit  = acc_wr && (paddr_i == REG_CMD);
	assign cmd_take = cmd_hit && !busy_q;

	// command while a byte is running is refused
	assign pslverr_o = cmd_hit && busy_q;

	always_ff @(posedge scl)
	begin
		if (rst_i)
		begin
			busy_q   <= 1'b0;
			rxnack_q <= 1'b0;
			go_q     <= 1'b0;
			cmd_q    <= '0;
			rx_q     <= '0;
		end
		else
		begin
			go_q <= cmd_take; // one pulse per accepted command
			if (cmd_take)
			begin
				busy_q <= 1'b1;
				cmd_q  <= pwdata_i[CMD_W-1:0];
			end
			else if (done_i)
				busy_q <= 1'b0;

			if (done_i)
			begin
				rx_q     <= rx_byte_i;
				rxnack_q <= rx_nack_i;
			end
		end
	end

	always_ff @(posedge scl)
	begin
		if (acc_wr && (paddr_i == REG_TX))
			tx_q <= pwdata_i[7:0];
	end

	// read mux, valid during the access phase
	always_comb
	begin
		prdata_o = '0;
		case (paddr_i)
			REG_TX:  prdata_o[7:0] = tx_q;
			REG_RX:  prdata_o[7:0] = rx_q;
			REG_CMD: prdata_o[CMD_W-1:0] = cmd_q; // last accepted command
			REG_STATUS:
			begin
				prdata_o[ST_BUSY]   = busy_q;
				prdata_o[ST_RXNACK] = rxnack_q;
			end
			default: prdata_o = '0;
		endcase
	end

	assign cmd_go_o   = go_q;
	assign cmd_sta_o  = cmd_q[CMD_STA];
	assign cmd_sto_o  = cmd_q[CMD_STO];
	assign cmd_rd_o   = cmd_q[CMD_RD];
	assign cmd_wr_o   = cmd_q[CMD_WR];
	assign cmd_nack_o = cmd_q[CMD_NACK];
	assign tx_byte_o  = tx_q;

endmodule

// File: logic/apb_regs_pkg.sv
// APB register map: bus widths, register offsets, command and status bit positions
package apb_regs_pkg;

	localparam int APB_AW = 4;
	localparam int APB_DW = 32;

	// word offsets
	localparam logic [APB_AW-1:0] REG_TX     = 4'h0; // byte to send
	localparam logic [APB_AW-1:0] REG_RX     = 4'h4; // last byte received
	localparam logic [APB_AW-1:0] REG_CMD    = 4'h8; // writing starts a byte operation
	localparam logic [APB_AW-1:0] REG_STATUS = 4'hC;

	// command word, bit positions
	localparam int CMD_STA  = 0; // start (or repeated start) first
	localparam int CMD_STO  = 1; // stop afterwards
	localparam int CMD_RD   = 2;
	localparam int CMD_WR   = 3;
	localparam int CMD_NACK = 4; // ack level to send on a read
	localparam int CMD_W    = 5;

	// status word, bit positions
	localparam int ST_BUSY   = 0;
	localparam int ST_RXNACK = 1; // ack bit seen on the bus, 1 = nack

endpackage

// File: logic/i2c_bit_engine.sv
// I2C master bit engine: start, eight data bits, ack bit and stop at a divided rate
`timescale 1ns/1ns

module i2c_bit_engine #(
	parameter int CLK_DIV = 4
) (
	input  logic       scl,
	input  logic       rst_i,
	input  logic       go_i,
	input  logic       sta_i,
	input  logic       sto_i,
	input  logic       rd_i,
	input  logic       wr_i,
	input  logic       nack_i,
	input  logic [7:0] tx_byte_i,
	input  logic       bus_clk_i,
	input  logic       bus_dat_i,
	output logic       clk_low_o,
	output logic       dat_low_o,
	output logic       done_o,
	output logic [7:0] rx_byte_o,
	output logic       rx_nack_o
);

	import i2c_bus_pkg::*;

	localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
	localparam logic [DIV_W-1:0] DIV_MAX = DIV_W'(CLK_DIV - 1);

	// operation steps
	localparam logic [1:0] E_IDLE  = 2'd0;
	localparam logic [1:0] E_START = 2'd1;
	localparam logic [1:0] E_BITS  = 2'd2;
	localparam logic [1:0] E_STOP  = 2'd3;

	logic [1:0]       step_q;
	phase_e           ph_q;
	logic [DIV_W-1:0] div_q;
	logic [3:0]       bit_q;  // 0..7 data, 8 ack
	logic             held_q; // clock kept low between bytes
	logic             done_q;
	logic             sto_q, rd_q, nack_q, byte_q;
	logic [7:0]       tx_sr, rx_sr;
	logic             ack_q;
	logic             start_op, stall, adv, bit_end, smp_en, out_low;

	assign start_op = (step_q == E_IDLE) && go_i;
	// hold in PH_RISE until the line really is high
	assign stall    = (ph_q == PH_RISE) && !bus_clk_i;
	assign adv      = (step_q != E_IDLE) && !stall && (div_q == DIV_MAX);
	assign bit_end  = adv && (ph_q == PH_FALL);
	assign smp_en   = adv && (ph_q == PH_HIGH) && (step_q == E_BITS);

	// level wanted on the data line during a byte, 1 = pull low
	assign out_low = (bit_q == 4'd8) ? (rd_q && !nack_q) : (!rd_q && !tx_sr[7]);

	always_ff @(posedge scl)
	begin
		if (rst_i)
		begin
			step_q <= E_IDLE;
			ph_q   <= PH_LOW;
			div_q  <= '0;
			bit_q  <= '0;
			held_q <= 1'b0;
			done_q <= 1'b0;
		end
		else
		begin
			done_q <= 1'b0;
			if (start_op)
			begin
				ph_q  <= PH_LOW;
				div_q <= '0;
				bit_q <= '0;
				if (sta_i)
					step_q <= E_START;
				else if (rd_i || wr_i)
					step_q <= E_BITS;
				else if (sto_i)
					step_q <= E_STOP;
				else
					done_q <= 1'b1; // empty command
			end
			else if (step_q != E_IDLE && !stall)
			begin
				if (div_q == DIV_MAX)
				begin
					div_q <= '0;
					ph_q  <= (ph_q == PH_FALL) ? PH_LOW : phase_e'(ph_q + 2'd1);
				end
				else
					div_q <= div_q + 1'b1;

				if (bit_end)
				begin
					case (step_q)
						E_START:
						begin
							if (byte_q)
								step_q <= E_BITS;
							else if (sto_q)
								step_q <= E_STOP;
							else
							begin
								step_q <= E_IDLE;
								held_q <= 1'b1;
								done_q <= 1'b1;
							end
						end
						E_BITS:
						begin
							if (bit_q != 4'd8)
								bit_q <= bit_q + 4'd1;
							else if (sto_q)
								step_q <= E_STOP;
							else
							begin
								step_q <= E_IDLE;
								held_q <= 1'b1; // keep the bus for the next byte
								done_q <= 1'b1;
							end
						end
						default:
						begin
							step_q <= E_IDLE;
							held_q <= 1'b0; // bus is free after the stop
							done_q <= 1'b1;
						end
					endcase
				end
			end
		end
	end

	// latched flags and the two shift registers
	always_ff @(posedge scl)
	begin
		if (start_op)
		begin
			sto_q  <= sto_i;
			rd_q   <= rd_i;
			nack_q <= nack_i;
			byte_q <= rd_i || wr_i;
			tx_sr  <= tx_byte_i;
		end
		else if (bit_end && (step_q == E_BITS))
			tx_sr <= {tx_sr[6:0], 1'b1};

		if (smp_en)
		begin
			if (bit_q == 4'd8)
				ack_q <= bus_dat_i;
			else
				rx_sr <= {rx_sr[6:0], bus_dat_i};
		end
	end

	always_comb
	begin
		clk_low_o = 1'b0;
		dat_low_o = 1'b0;
		case (step_q)
			E_IDLE: clk_low_o = held_q;
			E_START:
			begin
				// data falls while the clock is high
				clk_low_o = (ph_q == PH_LOW) ? held_q : (ph_q == PH_FALL);
				dat_low_o = (ph_q == PH_HIGH) || (ph_q == PH_FALL);
			end
			E_BITS:
			begin
				clk_low_o = (ph_q == PH_LOW) || (ph_q == PH_FALL);
				dat_low_o = out_low;
			end
			default:
			begin
				// stop: data rises while the clock is high
				clk_low_o = (ph_q == PH_LOW);
				dat_low_o = (ph_q == PH_LOW) || (ph_q == PH_RISE);
			end
		endcase
	end

	assign done_o    = done_q;
	assign rx_byte_o = rx_sr;
	assign rx_nack_o = ack_q;

endmodule

// File: logic/i2c_bus_pkg.sv
// bus-side types: slave state encoding, bit phase encoding, first byte decode
package i2c_bus_pkg;

	// memory slave FSM, one 3-bit word
	typedef enum logic [2:0] {
		SL_IDLE     = 3'd0, // waiting for an address byte after a start
		SL_ADDR_ACK = 3'd1,
		SL_PTR      = 3'd2, // receiving the memory pointer
		SL_PTR_ACK  = 3'd3,
		SL_DATA     = 3'd4, // write bytes in, or read bytes out
		SL_DATA_ACK = 3'd5
	} slave_state_e;

	// quarter phases of one bit period on the bus
	// data bits change on entry to PH_LOW and are sampled at the end of PH_HIGH
	typedef enum logic [1:0] {
		PH_LOW  = 2'd0, // clock low, data may move
		PH_RISE = 2'd1, // clock released
		PH_HIGH = 2'd2, // clock high, sample point at the end
		PH_FALL = 2'd3  // clock pulled low again
	} phase_e;

	// the slave's shift register seen two ways
	// after a start the byte is address plus direction, later it is pointer or data
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [6:0] addr; // device address, msb first on the wire
			logic       rw;   // 1 = read
		} hdr;
	} first_byte_u;

endpackage

// File: logic/i2c_mem_slave.sv
// oversampling I2C memory slave: address match, byte pointer, ack policy, read streaming
`timescale 1ns/1ns

module i2c_mem_slave #(
	parameter logic [6:0] SLAVE_ADDR = 7'h10,
	parameter int         MEM_DEPTH  = 16
) (
	input  logic scl,
	input  logic rst_i,
	input  logic bus_clk_i,
	input  logic bus_dat_i,
	output logic dat_low_o
);

	import i2c_bus_pkg::*;

	localparam int AW = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

	logic [1:0]   clk_sync_q, dat_sync_q;
	logic         clk_d_q, dat_d_q;
	logic         clk_s, dat_s;
	logic         clk_rise, clk_fall, sta_det, sto_det;
	slave_state_e state_q;
	first_byte_u  sr_q;
	logic [3:0]   cnt_q;   // rising edges seen in this byte
	logic         first_q; // next byte is the one after a start
	logic         rw_q;
	logic [7:0]   ptr_q;
	logic         drv_q;
	logic [7:0]   do_q;
	logic [7:0]   mem_q [MEM_DEPTH];
	logic         byte_in, in_range, ptr_ok, wr_en, load_rd, shift_rd;
	logic [7:0]   rd_val;

	// two-flop synchronizers, then one more stage for edges
	always_ff @(posedge scl)
	begin
		if (rst_i)
		begin
			clk_sync_q <= 2'b11;
			dat_sync_q <= 2'b11;
			clk_d_q    <= 1'b1;
			dat_d_q    <= 1'b1;
		end
		else
		begin
			clk_sync_q <= {clk_sync_q[0], bus_clk_i};
			dat_sync_q <= {dat_sync_q[0], bus_dat_i};
			clk_d_q    <= clk_sync_q[1];
			dat_d_q    <= dat_sync_q[1];
		end
	end

	assign clk_s    = clk_sync_q[1];
	assign dat_s    = dat_sync_q[1];
	assign clk_rise = clk_s && !clk_d_q;
	assign clk_fall = !clk_s && clk_d_q;
	assign sta_det  = clk_s && clk_d_q && dat_d_q && !dat_s; // data falls, clock high
	assign sto_det  = clk_s && clk_d_q && !dat_d_q && dat_s;

	assign byte_in  = (cnt_q == 4'd8);
	assign in_range = int'(ptr_q) < MEM_DEPTH;
	assign ptr_ok   = int'(sr_q.raw) < MEM_DEPTH;
	assign rd_val   = in_range ? mem_q[ptr_q[AW-1:0]] : 8'hFF;

	assign wr_en    = clk_fall && (state_q == SL_DATA) && !rw_q && byte_in && in_range;
	assign load_rd  = clk_fall && rw_q && ((state_q == SL_ADDR_ACK) ||
	                  ((state_q == SL_DATA_ACK) && !sr_q.raw[0]));
	assign shift_rd = clk_fall && rw_q && (state_q == SL_DATA) && !byte_in;

	always_ff @(posedge scl)
	begin
		if (clk_rise)
			sr_q.raw <= {sr_q.raw[6:0], dat_s};
	end

	always_ff @(posedge scl)
	begin
		if (rst_i)
		begin
			state_q <= SL_IDLE;
			cnt_q   <= '0;
			first_q <= 1'b0;
			rw_q    <= 1'b0;
			ptr_q   <= '0;
			drv_q   <= 1'b0;
		end
		else if (sta_det)
		begin
			state_q <= SL_IDLE;
			cnt_q   <= '0;
			first_q <= 1'b1;
			drv_q   <= 1'b0;
		end
		else if (sto_det)
		begin
			state_q <= SL_IDLE;
			first_q <= 1'b0;
			drv_q   <= 1'b0;
		end
		else if (clk_rise)
			cnt_q <= cnt_q + 4'd1;
		else if (clk_fall)
		begin
			// the bus moves on the falling clock edge
			case (state_q)
				SL_IDLE:
				begin
					if (byte_in)
					begin
						cnt_q   <= '0;
						first_q <= 1'b0;
						if (first_q && (sr_q.hdr.addr == SLAVE_ADDR))
						begin
							state_q <= SL_ADDR_ACK;
							rw_q    <= sr_q.hdr.rw;
							drv_q   <= 1'b1; // ack our address
						end
					end
				end
				SL_ADDR_ACK:
				begin
					cnt_q <= '0;
					if (rw_q)
					begin
						state_q <= SL_DATA;
						drv_q   <= !rd_val[7]; // first read bit, msb
					end
					else
					begin
						state_q <= SL_PTR;
						drv_q   <= 1'b0;
					end
				end
				SL_PTR:
				begin
					if (byte_in)
					begin
						cnt_q   <= '0;
						ptr_q   <= sr_q.raw;
						state_q <= SL_PTR_ACK;
						drv_q   <= ptr_ok; // nack a pointer past the end
					end
				end
				SL_PTR_ACK:
				begin
					cnt_q   <= '0;
					state_q <= SL_DATA;
					drv_q   <= 1'b0;
				end
				SL_DATA:
				begin
					if (byte_in)
					begin
						cnt_q   <= '0;
						state_q <= SL_DATA_ACK;
						ptr_q   <= ptr_q + 8'd1;
						drv_q   <= !rw_q && in_range; // release for the master's ack on reads
					end
					else if (rw_q)
						drv_q <= !do_q[7];
				end
				SL_DATA_ACK:
				begin
					cnt_q <= '0;
					if (rw_q && sr_q.raw[0])
					begin
						state_q <= SL_IDLE; // master nack ends the read
						drv_q   <= 1'b0;
					end
					else
					begin
						state_q <= SL_DATA;
						drv_q   <= rw_q && !rd_val[7];
					end
				end
				default: state_q <= SL_IDLE;
			endcase
		end
	end

	// read byte, already shifted past the bit on the wire
	always_ff @(posedge scl)
	begin
		if (load_rd)
			do_q <= {rd_val[6:0], 1'b1};
		else if (shift_rd)
			do_q <= {do_q[6:0], 1'b1};
	end

	always_ff @(posedge scl)
	begin
		if (rst_i)
		begin
			for (int i = 0; i < MEM_DEPTH; i++)
				mem_q[i] <= '0;
		end
		else if (wr_en)
			mem_q[ptr_q[AW-1:0]] <= sr_q.raw;
	end

	assign dat_low_o = drv_q;

endmodule

// File: logic/i2c_subsystem.sv
// top level: APB controller, bit engine, memory slave and the wired-AND I2C bus
`timescale 1ns/1ns

module i2c_subsystem #(
	parameter int         CLK_DIV    = 4,
	parameter logic [6:0] SLAVE_ADDR = 7'h10,
	parameter int         MEM_DEPTH  = 16
) (
	input  logic                            scl,
	input  logic                            rst_i,
	input  logic [apb_regs_pkg::APB_AW-1:0] paddr_i,
	input  logic                            psel_i,
	input  logic                            penable_i,
	input  logic                            pwrite_i,
	input  logic [apb_regs_pkg::APB_DW-1:0] pwdata_i,
	output logic [apb_regs_pkg::APB_DW-1:0] prdata_o,
	output logic                            pready_o,
	output logic                            pslverr_o
);

	logic       cmd_go, cmd_sta, cmd_sto, cmd_rd, cmd_wr, cmd_nack;
	logic [7:0] tx_byte, rx_byte;
	logic       eng_done, rx_nack;
	logic       eng_clk_low, eng_dat_low, slv_dat_low;
	logic       bus_clk, bus_dat;

	// open-drain lines, anyone pulling low wins
	assign bus_clk = !eng_clk_low;
	assign bus_dat = !(eng_dat_low || slv_dat_low);

	apb_i2c_ctrl u_apb_i2c_ctrl (
		.scl        (scl),
		.rst_i      (rst_i),
		.paddr_i    (paddr_i),
		.psel_i     (psel_i),
		.penable_i  (penable_i),
		.pwrite_i   (pwrite_i),
		.pwdata_i   (pwdata_i),
		.prdata_o   (prdata_o),
		.pready_o   (pready_o),
		.pslverr_o  (pslverr_o),
		.cmd_go_o   (cmd_go),
		.cmd_sta_o  (cmd_sta),
		.cmd_sto_o  (cmd_sto),
		.cmd_rd_o   (cmd_rd),
		.cmd_wr_o   (cmd_wr),
		.cmd_nack_o (cmd_nack),
		.tx_byte_o  (tx_byte),
		.done_i     (eng_done),
		.rx_byte_i  (rx_byte),
		.rx_nack_i  (rx_nack)
	);

	i2c_bit_engine #(
		.CLK_DIV (CLK_DIV)
	) u_i2c_bit_engine (
		.scl       (scl),
		.rst_i     (rst_i),
		.go_i      (cmd_go),
		.sta_i     (cmd_sta),
		.sto_i     (cmd_sto),
		.rd_i      (cmd_rd),
		.wr_i      (cmd_wr),
		.nack_i    (cmd_nack),
		.tx_byte_i (tx_byte),
		.bus_clk_i (bus_clk),
		.bus_dat_i (bus_dat),
		.clk_low_o (eng_clk_low),
		.dat_low_o (eng_dat_low),
		.done_o    (eng_done),
		.rx_byte_o (rx_byte),
		.rx_nack_o (rx_nack)
	);

	i2c_mem_slave #(
		.SLAVE_ADDR (SLAVE_ADDR),
		.MEM_DEPTH  (MEM_DEPTH)
	) u_i2c_mem_slave (
		.scl       (scl),
		.rst_i     (rst_i),
		.bus_clk_i (bus_clk),
		.bus_dat_i (bus_dat),
		.dat_low_o (slv_dat_low)
	);

endmodule

// File: testbench/i2c_subsystem_sva.sv
// bound assertions: bus data timing, APB ready, busy release, slave drive window
`timescale 1ns/1ns

module i2c_subsystem_sva (
	input logic                       scl,
	input logic                       rst_i,
	input logic                       psel_i,
	input logic                       penable_i,
	input logic                       pready_o,
	input logic                       bus_dat_i,
	input logic [1:0]                 eng_step_i,
	input i2c_bus_pkg::phase_e        ph_i,
	input logic                       busy_i,
	input logic                       done_i,
	input logic                       slv_low_i,
	input i2c_bus_pkg::slave_state_e  slv_state_i,
	input logic                       slv_rw_i
);

	import i2c_bus_pkg::*;

	int fail_cnt = 0; // assertion failures, read by the testbench top

	// inside a byte the data line moves only while the clock is low
	a_dat_low_phase: assert property (@(posedge scl) disable iff (rst_i)
		(eng_step_i == 2'd2 && $past(eng_step_i) == 2'd2 && $changed(bus_dat_i))
		|-> (ph_i == PH_LOW || ph_i == PH_FALL))
		else
		begin
			$error("bus data changed with the clock high inside a byte");
			fail_cnt++;
		end

	a_pready: assert property (@(posedge scl) disable iff (rst_i)
		(psel_i && penable_i) |-> pready_o)
		else
		begin
			$error("pready_o low in an access phase");
			fail_cnt++;
		end

	a_busy_done: assert property (@(posedge scl) disable iff (rst_i)
		$fell(busy_i) |-> $past(done_i))
		else
		begin
			$error("busy dropped without done");
			fail_cnt++;
		end

	// slave pulls data only for its acks and for read data
	a_slv_drive: assert property (@(posedge scl) disable iff (rst_i)
		slv_low_i |-> (slv_state_i == SL_ADDR_ACK || slv_state_i == SL_PTR_ACK ||
			(slv_state_i == SL_DATA_ACK && !slv_rw_i) || (slv_state_i == SL_DATA && slv_rw_i)))
		else
		begin
			$error("slave pulled data low outside ack or read data");
			fail_cnt++;
		end

endmodule

// File: testbench/tb_checker.sv
// APB response checker: expectation queue, compare on each access phase, error counts
`timescale 1ns/1ns

module tb_checker (
	input logic                            scl,
	input logic [apb_regs_pkg::APB_AW-1:0] paddr_i,
	input logic                            psel_i,
	input logic                            penable_i,
	input logic [apb_regs_pkg::APB_DW-1:0] prdata_i,
	input logic                            pslverr_i
);

	string       q_name [$];
	logic [31:0] q_data [$];
	bit          q_chk  [$];
	bit          q_err  [$];
	int          err_cnt   = 0;
	int          chk_cnt   = 0;
	int          test_cnt  = 0;
	int          err_start = 0;

	// one entry per APB access, queued by the top before it drives the access
	task automatic expect_access(input string name, input logic [31:0] data,
			input bit chk, input bit err);
		q_name.push_back(name);
		q_data.push_back(data);
		q_chk.push_back(chk);
		q_err.push_back(err);
	endtask

	// mid-cycle of the access phase, all responses settled
	always @(negedge scl)
	begin
		string       name;
		logic [31:0] data;
		bit          chk;
		bit          err;
		if (psel_i && penable_i)
		begin
			if (q_name.size() == 0)
			begin
				$display("APB access at %0t ns to address %h had nothing to compare against",
					$time, paddr_i);
				err_cnt++;
			end
			else
			begin
				name = q_name.pop_front();
				data = q_data.pop_front();
				chk  = q_chk.pop_front();
				err  = q_err.pop_front();
				chk_cnt++;
				if (pslverr_i !== err)
				begin
					$display("** Error at %0t ns: pslverr_o (%s) = %b, expected %b",
						$time, name, pslverr_i, err);
					err_cnt++;
				end
				if (chk && (prdata_i !== data))
				begin
					$display("** Error at %0t ns: prdata_o (%s) = %h, expected %h",
						$time, name, prdata_i, data);
					err_cnt++;
				end
			end
		end
	end

	task automatic test_done(input string name);
		$display("test %-18s %s (%0d errors)", name,
			(err_cnt == err_start) ? "ok" : "bad", err_cnt - err_start);
		test_cnt++;
		err_start = err_cnt;
	endtask

	task automatic report();
		$display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
	endtask

endmodule

// File: testbench/tb_clock_gen.sv
// testbench clock and reset source: 10 ns scl, reset held for 8 cycles
`timescale 1ns/1ns

module tb_clock_gen (
	output logic scl,
	output logic rst_i
);

	initial
	begin
		scl = 1'b0;
		forever #5 scl = ~scl;
	end

	initial
	begin
		rst_i = 1'b1;
		repeat (8) @(posedge scl);
		#2 rst_i = 1'b0; // released with the other inputs, 2 ns after the edge
	end

endmodule

// File: testbench/tb_i2c_subsystem.sv
// testbench top: APB tasks, LCG, reference slave model and the test sequence
`timescale 1ns/1ns

module tb_i2c_subsystem;

	import apb_regs_pkg::*;

	localparam int         CLK_DIV     = 4;
	localparam logic [6:0] SLAVE_ADDR  = 7'h10;
	localparam int         MEM_DEPTH   = 16;
	localparam int         N_BYTE_CMDS = 39;
	localparam int         MAX_CYCLES  = N_BYTE_CMDS * (11 * 4 * CLK_DIV + 10) + 200;

	// reference byte kinds
	localparam int K_ADDR = 0;
	localparam int K_PTR  = 1;
	localparam int K_WR   = 2;
	localparam int K_RD   = 3;

	localparam logic [4:0] C_STA  = 5'(1 << CMD_STA);
	localparam logic [4:0] C_STO  = 5'(1 << CMD_STO);
	localparam logic [4:0] C_RD   = 5'(1 << CMD_RD);
	localparam logic [4:0] C_WR   = 5'(1 << CMD_WR);
	localparam logic [4:0] C_NACK = 5'(1 << CMD_NACK);

	logic        scl, rst_i;
	logic [3:0]  paddr;
	logic        psel, penable, pwrite;
	logic [31:0] pwdata, prdata;
	logic        pready, pslverr;

	logic [7:0]  ref_mem [MEM_DEPTH];
	logic [7:0]  ref_ptr;
	logic        ref_sel;
	logic        last_nack; // ack bit of the last finished byte, kept in status while busy
	logic [31:0] lcg_state = 32'd74;
	logic [7:0]  aw, ar, bad_aw;
	logic [7:0]  wr_bytes [5];
	int          cycles = 0;

	tb_clock_gen u_tb_clock_gen (.scl(scl), .rst_i(rst_i));

	i2c_subsystem #(
		.CLK_DIV    (CLK_DIV),
		.SLAVE_ADDR (SLAVE_ADDR),
		.MEM_DEPTH  (MEM_DEPTH)
	) u_i2c_subsystem (
		.scl       (scl),
		.rst_i     (rst_i),
		.paddr_i   (paddr),
		.psel_i    (psel),
		.penable_i (penable),
		.pwrite_i  (pwrite),
		.pwdata_i  (pwdata),
		.prdata_o  (prdata),
		.pready_o  (pready),
		.pslverr_o (pslverr)
	);

	tb_checker u_checker (
		.scl       (scl),
		.paddr_i   (paddr),
		.psel_i    (psel),
		.penable_i (penable),
		.prdata_i  (prdata),
		.pslverr_i (pslverr)
	);

	bind i2c_subsystem i2c_subsystem_sva u_i2c_subsystem_sva (
		.scl         (scl),
		.rst_i       (rst_i),
		.psel_i      (psel_i),
		.penable_i   (penable_i),
		.pready_o    (pready_o),
		.bus_dat_i   (bus_dat),
		.eng_step_i  (u_i2c_bit_engine.step_q),
		.ph_i        (u_i2c_bit_engine.ph_q),
		.busy_i      (u_apb_i2c_ctrl.busy_q),
		.done_i      (eng_done),
		.slv_low_i   (slv_dat_low),
		.slv_state_i (u_i2c_mem_slave.state_q),
		.slv_rw_i    (u_i2c_mem_slave.rw_q)
	);

	function automatic logic [7:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	// expected {ack bit, rx byte} for one byte on the bus, updates the model
	function automatic logic [8:0] ref_byte(input int kind, input logic [7:0] b,
			input logic nack);
		logic       ack_bit;
		logic [7:0] rx;
		ack_bit = 1'b1;
		rx      = b; // on writes the engine reads back its own bits
		case (kind)
			K_ADDR:
			begin
				ref_sel = (b[7:1] == SLAVE_ADDR);
				ack_bit = !ref_sel;
			end
			K_PTR:
			begin
				if (ref_sel)
				begin
					ref_ptr = b;
					ack_bit = !(int'(b) < MEM_DEPTH);
				end
			end
			K_WR:
			begin
				if (ref_sel)
				begin
					ack_bit = !(int'(ref_ptr) < MEM_DEPTH);
					if (!ack_bit)
						ref_mem[ref_ptr] = b;
					ref_ptr = ref_ptr + 8'd1;
				end
			end
			default:
			begin
				rx = (ref_sel && int'(ref_ptr) < MEM_DEPTH) ? ref_mem[ref_ptr] : 8'hFF;
				ref_ptr = ref_ptr + 8'd1;
				ack_bit = nack; // master drives its own ack level
			end
		endcase
		return {ack_bit, rx};
	endfunction

	task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
			input bit err, input string name);
		u_checker.expect_access(name, 32'h0, 1'b0, err);
		@(posedge scl);
		#2;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(posedge scl);
		#2 penable = 1'b1;
		@(posedge scl);
		#2;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
		@(posedge scl);
		#2;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(posedge scl);
		#2 penable = 1'b1;
		#6 data = prdata;
		@(posedge scl);
		#2;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_check(input logic [3:0] addr, input logic [31:0] exp,
			input string name);
		logic [31:0] d;
		u_checker.expect_access(name, exp, 1'b1, 1'b0);
		apb_read(addr, d);
	endtask

	task automatic wait_idle();
		logic [31:0] st;
		do
		begin
			u_checker.expect_access("STATUS poll", 32'h0, 1'b0, 1'b0);
			apb_read(REG_STATUS, st);
		end
		while (st[ST_BUSY]);
	endtask

	task automatic check_status(input logic nack);
		logic [31:0] exp;
		exp = '0;
		exp[ST_RXNACK] = nack;
		last_nack = nack;
		apb_check(REG_STATUS, exp, "STATUS");
	endtask

	task automatic byte_op(input logic [4:0] cmd, input logic [7:0] tx, input int kind);
		logic [8:0] exp;
		exp = ref_byte(kind, tx, cmd[CMD_NACK]);
		apb_write(REG_TX, {24'h0, tx}, 1'b0, "TX");
		apb_write(REG_CMD, {27'h0, cmd}, 1'b0, "CMD");
		wait_idle();
		if (cmd[CMD_RD])
			apb_check(REG_RX, {24'h0, exp[7:0]}, "RX");
		check_status(exp[8]);
	endtask

	// hang guard
	always @(posedge scl)
	begin
		cycles++;
		if (cycles > MAX_CYCLES)
		begin
			$display("run stopped after %0d cycles without finishing the tests", cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial
	begin
		logic [8:0] exp;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		ref_ptr = '0;
		ref_sel = 1'b0;
		last_nack = 1'b0;
		for (int i = 0; i < MEM_DEPTH; i++)
			ref_mem[i] = '0;
		aw     = {SLAVE_ADDR, 1'b0};
		ar     = {SLAVE_ADDR, 1'b1};
		bad_aw = {SLAVE_ADDR ^ 7'h05, 1'b0};
		@(negedge rst_i);

		apb_check(REG_STATUS, 32'h0, "STATUS");
		apb_check(REG_RX, 32'h0, "RX");
		u_checker.test_done("reset");

		for (int i = 0; i < 5; i++)
			wr_bytes[i] = lcg_next();
		byte_op(C_STA | C_WR, aw, K_ADDR);
		byte_op(C_WR, 8'd3, K_PTR);
		for (int i = 0; i < 5; i++)
			byte_op((i == 4) ? (C_WR | C_STO) : C_WR, wr_bytes[i], K_WR);
		byte_op(C_STA | C_WR, aw, K_ADDR);
		byte_op(C_WR, 8'd3, K_PTR);
		byte_op(C_STA | C_WR, ar, K_ADDR); // repeated start
		for (int i = 0; i < 5; i++)
			byte_op((i == 4) ? (C_RD | C_NACK | C_STO) : C_RD, 8'h00, K_RD);
		u_checker.test_done("write_read");

		byte_op(C_STA | C_WR, bad_aw, K_ADDR);
		byte_op(C_WR, 8'd3, K_PTR);
		byte_op(C_WR | C_STO, ~wr_bytes[0], K_WR);
		byte_op(C_STA | C_WR, aw, K_ADDR);
		byte_op(C_WR, 8'd3, K_PTR);
		byte_op(C_STA | C_WR, ar, K_ADDR);
		byte_op(C_RD | C_NACK | C_STO, 8'h00, K_RD);
		u_checker.test_done("wrong_address");

		byte_op(C_STA | C_WR, aw, K_ADDR);
		byte_op(C_WR, 8'(MEM_DEPTH), K_PTR);
		byte_op(C_WR | C_STO, lcg_next(), K_WR);
		byte_op(C_STA | C_WR, aw, K_ADDR);
		byte_op(C_WR, 8'(MEM_DEPTH - 2), K_PTR);
		for (int i = 0; i < 3; i++)
			byte_op((i == 2) ? (C_WR | C_STO) : C_WR, lcg_next(), K_WR);
		byte_op(C_STA | C_WR, aw, K_ADDR);
		byte_op(C_WR, 8'(MEM_DEPTH - 2), K_PTR);
		byte_op(C_STA | C_WR, ar, K_ADDR);
		for (int i = 0; i < 4; i++)
			byte_op((i == 3) ? (C_RD | C_NACK | C_STO) : C_RD, 8'h00, K_RD);
		u_checker.test_done("pointer_range");

		// second command lands while the address byte is still on the bus
		exp = ref_byte(K_ADDR, aw, 1'b0);
		apb_write(REG_TX, {24'h0, aw}, 1'b0, "TX");
		apb_write(REG_CMD, {27'h0, C_STA | C_WR}, 1'b0, "CMD");
		apb_check(REG_STATUS, (32'h1 << ST_BUSY) | (32'(last_nack) << ST_RXNACK), "STATUS");
		apb_write(REG_CMD, {27'h0, C_WR | C_STO}, 1'b1, "CMD busy");
		wait_idle();
		check_status(exp[8]);
		byte_op(C_WR | C_STO, 8'd0, K_PTR);
		u_checker.test_done("busy_refusal");

		u_checker.report();
		if (u_checker.err_cnt == 0 && u_i2c_subsystem.u_i2c_subsystem_sva.fail_cnt == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: verilog.f
logic/i2c_bus_pkg.sv
logic/apb_regs_pkg.sv
logic/apb_i2c_ctrl.sv
logic/i2c_bit_engine.sv
logic/i2c_mem_slave.sv
logic/i2c_subsystem.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/i2c_subsystem_sva.sv
testbench/tb_i2c_subsystem.sv
